// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tx_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/clock_divider.sv
`timescale 1ns/1ns

// Stands in for the div-by-2 chain that makes the half-rate and word clocks.
// Everything stays on mdll_clk and the slower domains become strobes.
module clock_divider (
    input  logic                                mdll_clk,  // Bit clock
    input  logic                                rst_n,
    output logic                                word_stb,  // Last slot of a word
    output logic                                lane_stb,  // Last slot of a nibble
    output logic [tx_const_pkg::lane_sel_w-1:0] slot       // Lane phase for the 4:1 mux
);
    import tx_const_pkg::*;

    logic [slot_w-1:0] cnt;  // Bit slot within the word

    // Free running, wraps 15 -> 0 with no gap
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Word boundary once per wrap
    assign word_stb = (cnt == {slot_w{1'b1}});

    // Every lane_n slots
    assign lane_stb = (cnt[lane_sel_w-1:0] == {lane_sel_w{1'b1}});

    // Low bits give the quarter-rate phase directly
    assign slot = cnt[lane_sel_w-1:0];

endmodule

// File: logic/hr_16t4_mux.sv
`timescale 1ns/1ns

// 16:4 stage. Source holds the word for the whole period, so this block
// only keeps the nibble pointer and steers four word bits onto the lanes.
module hr_16t4_mux (
    input  logic                            mdll_clk,
    input  logic                            rst_n,
    input  logic                            word_stb,  // Restart at nibble 0
    input  logic                            lane_stb,  // Next nibble
    input  logic [tx_const_pkg::word_w-1:0] word,
    output logic [tx_const_pkg::lane_n-1:0] lanes      // Nibble for the 4:1 mux
);
    import tx_const_pkg::*;

    logic [word_w-1:0]     word_ro;  // Interleaved word
    logic [lane_sel_w-1:0] step;     // Nibble pointer

    // Second 2:1 level of the tree runs on the opposite phase,
    // hence the swapped pointer bits
    function automatic logic [lane_sel_w-1:0] bit_rev(input logic [lane_sel_w-1:0] k);
        logic [lane_sel_w-1:0] r;
        for (int b = 0; b < lane_sel_w; b++) begin
            r[b] = k[lane_sel_w-1-b];
        end
        return r;
    endfunction

    // Same interleave as the silicon mux input
    // MSB group lands on index 0,4,8,12, next on 2,6,10,14, then 1,5.. and 3,7..
    always_comb begin
        word_ro = '0;
        for (int g = 0; g < lane_w; g++) begin
            for (int m = 0; m < lane_n; m++) begin
                word_ro[lane_w*m + bit_rev(g[lane_sel_w-1:0])] = word[word_w-1 - lane_n*g - m];
            end
        end
    end

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (word_stb) begin
            step <= '0;            // Wins over lane_stb on the last slot
        end else if (lane_stb) begin
            step <= step + 1'b1;
        end
    end

    // Lane j of nibble k carries serial bit 4k+j
    always_comb begin
        for (int j = 0; j < lane_n; j++) begin
            lanes[j] = word_ro[lane_w*j + bit_rev(step)];
        end
    end

endmodule

// File: logic/output_driver.sv
`timescale 1ns/1ns

// Whole-bit delay in place of the PI phase code, then the pair register
module output_driver #(
    parameter int ndelay = 4  // Delay taps, 0..ndelay-1 bits
) (
    input  logic                      mdll_clk,
    input  logic                      rst_n,
    input  logic                      word_stb,   // Word boundary at the source
    input  logic                      bit_in,     // From the 4:1 mux
    input  logic [$clog2(ndelay)-1:0] ctl_pi,     // Delay in bits
    input  logic                      ctl_valid,  // Latch ctl_pi
    input  logic                      en_drv,
    input  logic                      invert,     // Swap data polarity
    output logic                      dout_p,
    output logic                      dout_n
);
    import tx_mode_pkg::*;

    localparam int mux_lat = 2;  // Source register to bit_in, in cycles

    logic [mux_lat-1:0]          stb_pipe;  // Marker in line with bit_in MSB
    logic [ndelay-1:0][1:0]      taps;      // {marker, data}, tap k is k bits late
    logic [ndelay-2:0][1:0]      dly_q;     // Delay line
    logic [$clog2(ndelay)-1:0]   dly_sel;   // Latched delay
    logic [1:0]                  tap_sel;
    logic                        mark;      // First bit of a word at the output
    logic                        data;
    drv_state_e                  state;
    drv_state_e                  state_d;

    // Marker and data share one line so they stay aligned for any delay
    assign taps    = {dly_q, {stb_pipe[mux_lat-1], bit_in}};
    assign tap_sel = taps[dly_sel];
    assign mark    = tap_sel[1];
    assign data    = tap_sel[0] ^ invert;

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            stb_pipe <= '0;
            dly_q    <= '0;
            dly_sel  <= '0;
        end else begin
            stb_pipe <= {stb_pipe[mux_lat-2:0], word_stb};
            dly_q    <= taps[ndelay-2:0];  // Shift by one tap
            if (ctl_valid) begin
                dly_sel <= ctl_pi;
            end
        end
    end

    // Idle waits for a word start so data begins on a boundary
    always_comb begin
        state_d = state;
        case (state)
            drv_off: begin
                if (en_drv) begin
                    state_d = drv_idle;
                end
            end
            drv_idle: begin
                if (!en_drv) begin
                    state_d = drv_off;
                end else if (mark) begin
                    state_d = drv_on;
                end
            end
            drv_on: begin
                if (!en_drv) begin
                    state_d = drv_off;
                end
            end
            default: state_d = drv_off;
        endcase
    end

    // Pair follows the next state, so en_drv acts in one cycle
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= drv_off;
            dout_p <= 1'b0;
            dout_n <= 1'b0;
        end else begin
            state <= state_d;
            case (state_d)
                drv_on: begin
                    dout_p <= data;
                    dout_n <= ~data;   // Always the complement
                end
                drv_idle: begin
                    dout_p <= 1'b0;
                    dout_n <= 1'b1;
                end
                default: begin
                    dout_p <= 1'b0;    // Driver off
                    dout_n <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: logic/pattern_gen.sv
`timescale 1ns/1ns

// Word source feeding the serializer at the clk_prbsgen rate
module pattern_gen #(
    parameter logic [tx_const_pkg::prbs_w-1:0] prbs_seed = '1  // PRBS7 start state
) (
    input  logic                            mdll_clk,
    input  logic                            rst_n,
    input  logic                            word_stb,  // Take a new word
    input  tx_mode_pkg::pattern_e           pattern,
    input  logic [tx_const_pkg::word_w-1:0] din,       // External data
    output logic [tx_const_pkg::word_w-1:0] word       // Held for a full word period
);
    import tx_const_pkg::*;
    import tx_mode_pkg::*;

    localparam logic [word_w-1:0] clock_word = {(word_w / 2){2'b10}};  // Starts with a 1 at the MSB

    logic [prbs_w-1:0] prbs_q;      // State between words
    logic [prbs_w-1:0] prbs_d;      // State after one word of steps
    logic [word_w-1:0] prbs_word;   // Bits of those steps
    logic [word_w-1:0] word_d;

    // Unroll word_w LFSR steps
    always_comb begin
        logic [prbs_w-1:0] st;
        logic              fb;
        st = prbs_q;
        for (int k = word_w - 1; k >= 0; k--) begin
            fb           = st[prbs_w-1] ^ st[prbs_w-2];  // Taps 7 and 6
            prbs_word[k] = fb;                           // First step goes out first
            st           = {st[prbs_w-2:0], fb};
        end
        prbs_d = st;
    end

    always_comb begin
        case (pattern)
            pat_ext:   word_d = din;
            pat_prbs7: word_d = prbs_word;
            pat_clock: word_d = clock_word;
            default:   word_d = '0;  // Unused code sends zeros
        endcase
    end

    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            prbs_q <= prbs_seed;
            word   <= '0;
        end else if (word_stb) begin
            word <= word_d;
            if (pattern == pat_prbs7) begin
                prbs_q <= prbs_d;  // Sequence only moves while it is sent
            end
        end
    end

endmodule

// File: logic/qr_4t1_mux.sv
`timescale 1ns/1ns

// 4:1 stage, one lane per bit slot
module qr_4t1_mux (
    input  logic                                mdll_clk,
    input  logic                                rst_n,
    input  logic [tx_const_pkg::lane_sel_w-1:0] slot,    // Lane phase
    input  logic [tx_const_pkg::lane_n-1:0]     lanes,   // Current nibble
    output logic                                bit_out  // Serial stream, MSB first
);
    import tx_const_pkg::*;

    logic [lane_n-1:0] phase;  // One-hot slot, plays the Q/I/QB/IB clocks
    logic              bit_d;

    // Only one phase active per bit slot
    always_comb begin
        phase       = '0;
        phase[slot] = 1'b1;
    end

    // AND-OR select like the clock-gated mux legs
    assign bit_d = |(lanes & phase);

    // Retimed to the bit clock
    always_ff @(posedge mdll_clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_out <= 1'b0;
        end else begin
            bit_out <= bit_d;
        end
    end

endmodule

// File: logic/tx_const_pkg.sv
package tx_const_pkg;

    // Parallel side of the link
    parameter int word_w = 16;  // Bits per word from the source

    // Quarter-rate lane split
    parameter int lane_n = 4;                // Lanes into the 4:1 mux
    parameter int lane_w = word_w / lane_n;  // Bits per lane per word

    // One count per bit slot, one wrap per word
    parameter int slot_w = 4;

    // Lane index and nibble pointer
    // Both are 2 bits since lane_n and lane_w are both 4
    parameter int lane_sel_w = $clog2(lane_n);

    // Pattern source
    parameter int prbs_w = 7;  // PRBS7 state register

endpackage

// File: logic/tx_mode_pkg.sv
package tx_mode_pkg;

    // Word source select
    typedef enum logic [1:0] {
        pat_ext   = 2'd0,  // Word sampled from din
        pat_prbs7 = 2'd1,  // x^7 + x^6 + 1 sequence
        pat_clock = 2'd2   // 1010... word, MSB is 1
    } pattern_e;

    // Output driver
    typedef enum logic [1:0] {
        drv_off  = 2'd0,  // Both legs low
        drv_idle = 2'd1,  // Pair parked at p=0, n=1
        drv_on   = 2'd2   // Serial data on the pair
    } drv_state_e;

endpackage

// File: logic/tx_top.sv
`timescale 1ns/1ns

// Transmit path: source -> 16:4 -> 4:1 -> driver, one bit per mdll_clk
module tx_top #(
    parameter int                              ndelay    = 4,   // Driver delay taps
    parameter logic [tx_const_pkg::prbs_w-1:0] prbs_seed = '1   // PRBS7 start
) (
    input  logic                            mdll_clk,     // Bit clock
    input  logic                            rst_n,
    input  logic [tx_const_pkg::word_w-1:0] din,          // External word
    input  tx_mode_pkg::pattern_e           pattern,
    input  logic [$clog2(ndelay)-1:0]       ctl_pi,       // Whole-bit delay
    input  logic                            ctl_valid,
    input  logic                            en_drv,
    input  logic                            invert,
    output logic                            clk_prbsgen,  // Word rate strobe
    output logic                            dout_p,       // Data output
    output logic                            dout_n
);
    import tx_const_pkg::*;

    logic                  word_stb;
    logic                  lane_stb;
    logic [lane_sel_w-1:0] slot;      // Quarter-rate phase
    logic [word_w-1:0]     word;      // Source word
    logic [lane_n-1:0]     lanes;     // 16:4 to 4:1
    logic                  mtb;       // Mux to buffer

    assign clk_prbsgen = word_stb;    // Paces the word source

    clock_divider i_clkdiv (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .word_stb (word_stb),
        .lane_stb (lane_stb),
        .slot     (slot)
    );

    pattern_gen #(
        .prbs_seed (prbs_seed)
    ) i_patgen (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .word_stb (word_stb),
        .pattern  (pattern),
        .din      (din),
        .word     (word)
    );

    hr_16t4_mux i_hr_mux (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .word_stb (word_stb),
        .lane_stb (lane_stb),
        .word     (word),
        .lanes    (lanes)
    );

    qr_4t1_mux i_qr_mux (
        .mdll_clk (mdll_clk),
        .rst_n    (rst_n),
        .slot     (slot),
        .lanes    (lanes),
        .bit_out  (mtb)
    );

    output_driver #(
        .ndelay (ndelay)
    ) i_drv (
        .mdll_clk  (mdll_clk),
        .rst_n     (rst_n),
        .word_stb  (word_stb),
        .bit_in    (mtb),
        .ctl_pi    (ctl_pi),
        .ctl_valid (ctl_valid),
        .en_drv    (en_drv),
        .invert    (invert),
        .dout_p    (dout_p),
        .dout_n    (dout_n)
    );

endmodule

// File: testbench/tb_tx_tasks.svh
// Released in cycle with count 0, so no word reaches the driver for a while
task automatic reset_and_idle();
    start_test("reset_and_idle");
    check_value("clk_prbsgen in reset", 1'b0, clk_prbsgen);
    check_value("dout_p in reset", 1'b0, dout_p);
    check_value("dout_n in reset", 1'b0, dout_n);
    rst_n = 1'b1;
    next_cycle();
    check_value("dout_p off", 1'b0, dout_p);
    check_value("dout_n off", 1'b0, dout_n);
    en_drv = 1'b1;
    next_cycle();  // Idle one cycle after en_drv
    while (clk_prbsgen !== 1'b1) begin
        check_value("dout_p idle", 1'b0, dout_p);
        check_value("dout_n idle", 1'b1, dout_n);
        next_cycle();
    end
    din = 16'h8000;  // First word starts with a 1
    for (int c = 0; c < pipe_lat; c++) begin
        check_value("dout_p idle at boundary", 1'b0, dout_p);
        check_value("dout_n idle at boundary", 1'b1, dout_n);
        next_cycle();
    end
    check_value("first data bit", 1'b1, dout_p);
    check_value("first data bit dout_n", 1'b0, dout_n);
    end_test();
endtask

task automatic serialize_ext_words();
    start_test("serialize_ext_words");
    for (int w = 0; w < 20; w++) begin
        exp_words[w] = lcg_word();
    end
    stream_words(20, 0, pat_ext, 1'b0);
    end_test();
endtask

task automatic pair_polarity();
    start_test("pair_polarity");
    for (int w = 0; w < 4; w++) begin
        exp_words[w] = lcg_word();
    end
    stream_words(4, 0, pat_ext, 1'b1);  // Inverted data on dout_p
    end_test();
endtask

task automatic prbs7_words();
    start_test("prbs7_words");
    prbs_state = 7'h7f;
    for (int w = 0; w < 8; w++) begin
        for (int b = 15; b >= 0; b--) begin
            exp_words[w][b] = prbs_bit();  // MSB is sent first
        end
    end
    stream_words(8, 0, pat_prbs7, 1'b0);
    end_test();
endtask

task automatic whole_bit_delay();
    start_test("whole_bit_delay");
    for (int d = 0; d < 4; d++) begin
        ctl_pi    = 2'(d);
        ctl_valid = 1'b1;
        next_cycle();
        ctl_valid = 1'b0;
        for (int w = 0; w < 4; w++) begin
            exp_words[w] = lcg_word();
        end
        stream_words(4, d, pat_ext, 1'b0);
    end
    ctl_pi    = '0;  // Later tests run undelayed
    ctl_valid = 1'b1;
    next_cycle();
    ctl_valid = 1'b0;
    end_test();
endtask

task automatic clock_pattern_and_disable();
    start_test("clock_pattern_and_disable");
    for (int w = 0; w < 4; w++) begin
        for (int k = 0; k < word_bits; k++) begin
            exp_words[w][word_bits - 1 - k] = (k % 2 == 0);  // 1 first, then alternate
        end
    end
    stream_words(4, 0, pat_clock, 1'b0);
    en_drv = 1'b0;
    for (int c = 0; c < word_bits; c++) begin
        next_cycle();  // Off from the first cycle on
        check_value("dout_p disabled", 1'b0, dout_p);
        check_value("dout_n disabled", 1'b0, dout_n);
    end
    end_test();
endtask

// File: testbench/tb_tx_top.sv
`timescale 1ns/1ns

module tb_tx_top;
    import tx_mode_pkg::*;

    localparam int word_bits   = 16;                       // Serial bits per word
    localparam int pipe_lat    = 3;                        // Word strobe to first bit on dout_p
    localparam int run_words   = 20 + 4 + 8 + 4 * 4 + 4;   // Words sent over all tests
    localparam int test_margin = 40;                       // Alignment and flush per test
    localparam int cycle_limit = 3 * (run_words * word_bits + 6 * test_margin);

    logic        mdll_clk;
    logic        rst_n;
    logic [15:0] din;
    pattern_e    pattern;
    logic [1:0]  ctl_pi;
    logic        ctl_valid;
    logic        en_drv;
    logic        invert;
    logic        clk_prbsgen;
    logic        dout_p;
    logic        dout_n;

    int          cycle_cnt;
    int          chk_cnt;
    int          err_cnt;
    int          test_cnt;
    int          test_fail_cnt;
    int          test_err_base;     // err_cnt at test start
    string       test_name;
    logic [31:0] lcg_state;
    logic [6:0]  prbs_state;        // Reference PRBS7 register
    logic [15:0] exp_words [0:31];  // Expected words in send order

    tx_top i_dut (
        .mdll_clk    (mdll_clk),
        .rst_n       (rst_n),
        .din         (din),
        .pattern     (pattern),
        .ctl_pi      (ctl_pi),
        .ctl_valid   (ctl_valid),
        .en_drv      (en_drv),
        .invert      (invert),
        .clk_prbsgen (clk_prbsgen),
        .dout_p      (dout_p),
        .dout_n      (dout_n)
    );

    initial begin
        mdll_clk = 1'b0;
        forever begin
            #50 mdll_clk = ~mdll_clk;  // 100 ns bit period
        end
    end

    // Run limit
    always @(posedge mdll_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, test %s did not finish", cycle_cnt, test_name);
            $display("Checks failed");
            $finish;
        end
    end

    // Upper half of the LCG state is the word
    function automatic logic [15:0] lcg_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    // x^7 + x^6 + 1 with the feedback bit as the one sent
    function automatic logic prbs_bit();
        logic fb;
        fb         = prbs_state[6] ^ prbs_state[5];
        prbs_state = {prbs_state[5:0], fb};
        return fb;
    endfunction

    task automatic next_cycle();
        @(posedge mdll_clk);
        #10;  // Drive and sample point
    endtask

    // Stops in the cycle where clk_prbsgen is high
    task automatic wait_word();
        next_cycle();
        while (clk_prbsgen !== 1'b1) begin
            next_cycle();
        end
    endtask

    task automatic check_value(string what, logic exp_val, logic act_val);
        chk_cnt++;
        if (act_val !== exp_val) begin
            err_cnt++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp_val, act_val);
        end
    endtask

    task automatic start_test(string name);
        test_name     = name;
        test_err_base = err_cnt;
        test_cnt++;
    endtask

    task automatic end_test();
        if (err_cnt == test_err_base) begin
            $display("PASS %s", test_name);
        end else begin
            test_fail_cnt++;
            $display("FAIL %s, %0d errors", test_name, err_cnt - test_err_base);
        end
    endtask

    // Sends n words of exp_words from the next boundary and checks the pair
    // at pipe_lat + dly. Non-external modes get the inverse on din so a leak shows
    task automatic stream_words(int n, int dly, pattern_e pat, logic inv);
        int   last;
        int   k;
        logic exp_bit;
        last = n * word_bits + pipe_lat + dly;
        wait_word();
        pattern = pat;
        invert  = inv;
        for (int c = 0; c < last; c++) begin
            if (c == n * word_bits) begin
                pattern = pat_ext;  // Back to din after the last word
                din     = '0;
            end else if (c % word_bits == 0) begin
                k   = c / word_bits;
                din = (pat == pat_ext) ? exp_words[k] : ~exp_words[k];
            end
            if (c >= pipe_lat + dly) begin
                k       = c - pipe_lat - dly;
                exp_bit = exp_words[k / word_bits][word_bits - 1 - k % word_bits] ^ inv;
                check_value($sformatf("dout_p bit %0d", k), exp_bit, dout_p);
                check_value($sformatf("dout_n bit %0d", k), ~exp_bit, dout_n);
            end
            next_cycle();
        end
        invert = 1'b0;
    endtask

    initial begin
        rst_n         = 1'b0;
        din           = '0;
        pattern       = pat_ext;
        ctl_pi        = '0;
        ctl_valid     = 1'b0;
        en_drv        = 1'b0;
        invert        = 1'b0;
        cycle_cnt     = 0;
        chk_cnt       = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        test_name     = "reset";
        lcg_state     = 32'd71;
        prbs_state    = 7'h7f;
        repeat (5) next_cycle();  // Reset held 5 cycles

        reset_and_idle();
        serialize_ext_words();
        pair_polarity();
        prbs7_words();
        whole_bit_delay();
        clock_pattern_and_disable();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_cnt, test_fail_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0 && chk_cnt > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    `include "tb_tx_tasks.svh"

endmodule

// File: verilog.f
+incdir+testbench
logic/tx_const_pkg.sv
logic/tx_mode_pkg.sv
logic/clock_divider.sv
logic/pattern_gen.sv
logic/hr_16t4_mux.sv
logic/qr_4t1_mux.sv
logic/output_driver.sv
logic/tx_top.sv
testbench/tb_tx_top.sv
